// File: build.f
+incdir+.
i2c_reg_pkg.sv
i2c_queue_pkg.sv
i2c_host_regs.sv
i2c_queue_stage.sv
i2c_write_engine.sv
i2c_master_wbs_top.sv
tb_i2c_master_assert.sv
tb_i2c_master.sv

// File: Bender.yml
package:
  name: i2c_master_wbs

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - i2c_reg_pkg.sv
      - i2c_queue_pkg.sv
      - i2c_host_regs.sv
      - i2c_queue_stage.sv
      - i2c_write_engine.sv
      - i2c_master_wbs_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_i2c_master_assert.sv
      - tb_i2c_master.sv

// File: tb_i2c_master.sv
//********************
// Directed testbench for the Wishbone I2C write master
// Wishbone driver, I2C slave model, tests and checks
//********************

`timescale 1ns/1ps
`include "i2c_defines.svh"

module tb_i2c_master;
  import i2c_reg_pkg::*;
  import i2c_queue_pkg::*;

  localparam int NUM_TESTS      = 6;
  localparam int MAX_BYTES      = 3;
  localparam int MAX_PRESCALE   = 200;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * (MAX_BYTES + 3) * 9 * 4 * MAX_PRESCALE + 5000;

  logic      clk;
  logic      rst;
  wb_addr_t  wbs_adr;
  wb_data_t  wbs_dat_w;
  wb_data_t  wbs_dat_r;
  logic      wbs_we;
  logic      wbs_stb;
  logic      wbs_cyc;
  logic      wbs_ack;
  logic      i2c_scl;
  logic      i2c_sda;
  wire       sda_line;
  logic      slave_sda;
  logic      nack_addr;
  int        start_count;
  int        stop_count;
  i2c_byte_t rx_bytes[$];
  i2c_byte_t rx_shift;
  int        rx_bits;
  logic      first_byte;
  logic      scl_prev;
  logic      sda_prev;
  int        word_errors;
  int        byte_errors;
  int        event_errors;
  int        cycle_count;
  logic [31:0] rng_state;

  // Open-drain line, slave pulls low for ACK
  assign sda_line = i2c_sda & slave_sda;

  i2c_master_wbs_top dut0 (
    .clk, .rst,
    .wbs_adr_i(wbs_adr), .wbs_dat_i(wbs_dat_w), .wbs_dat_o(wbs_dat_r), .wbs_we_i(wbs_we),
    .wbs_stb_i(wbs_stb), .wbs_cyc_i(wbs_cyc), .wbs_ack_o(wbs_ack),
    .i2c_sda_i(sda_line), .i2c_scl_o(i2c_scl), .i2c_sda_o(i2c_sda)
  );

  always #20 clk = ~clk;

  // Run limit from worst case test length
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // I2C slave model, samples the bus just after each rising edge
  always @(posedge clk) begin
    #2;
    if (rst) begin
      scl_prev  = 1'b1;
      sda_prev  = 1'b1;
      slave_sda = 1'b1;
      rx_bits   = 0;
    end else begin
      if (i2c_scl && scl_prev && sda_prev && !i2c_sda) begin
        start_count = start_count + 1;
        rx_bits     = 0;
        first_byte  = 1'b1;
      end else if (i2c_scl && scl_prev && !sda_prev && i2c_sda) begin
        stop_count = stop_count + 1;
        slave_sda  = 1'b1;
      end else if (i2c_scl && !scl_prev) begin
        if (rx_bits < 8) begin
          rx_shift = {rx_shift[6:0], i2c_sda};
          rx_bits  = rx_bits + 1;
          if (rx_bits == 8) begin
            rx_bytes.push_back(rx_shift);
          end
        end else begin
          // ACK clock
          rx_bits = 0;
        end
      end else if (!i2c_scl && scl_prev) begin
        // Drive the ACK slot after the eighth bit, release after it
        if (rx_bits == 8) begin
          slave_sda  = nack_addr && first_byte;
          first_byte = 1'b0;
        end else begin
          slave_sda = 1'b1;
        end
      end
      scl_prev = i2c_scl;
      sda_prev = i2c_sda;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // COMMAND layout: addr 6:0, start 8, write 10, write_multiple 11, stop 12
  function automatic wb_data_t command_word(input logic start, input logic wr,
                                            input logic wr_multi, input logic stop,
                                            input i2c_addr_t addr);
    return {3'b000, stop, wr_multi, wr, 1'b0, start, 1'b0, addr};
  endfunction

  // DATA layout: byte 7:0, last flag 9
  function automatic wb_data_t data_word(input i2c_byte_t data, input logic last);
    return {6'd0, last, 1'b0, data};
  endfunction

  function automatic wb_data_t status_bits(input logic busy, input logic miss,
                                           input logic empty, input logic full,
                                           input logic ovf);
    wb_data_t st;
    st = '0;
    st[ST_BUSY]     = busy;
    st[ST_MISS_ACK] = miss;
    st[ST_Q_EMPTY]  = empty;
    st[ST_Q_FULL]   = full;
    st[ST_Q_OVF]    = ovf;
    return st;
  endfunction

  // Called 2 ns after a rising edge, returns at the same offset
  task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
    wbs_adr   = addr;
    wbs_dat_w = data;
    wbs_we    = 1'b1;
    wbs_stb   = 1'b1;
    wbs_cyc   = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!wbs_ack);
    #1;
    wbs_cyc = 1'b0;
    wbs_stb = 1'b0;
    wbs_we  = 1'b0;
  endtask

  task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
    wbs_adr = addr;
    wbs_we  = 1'b0;
    wbs_stb = 1'b1;
    wbs_cyc = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!wbs_ack);
    // Read data valid in the ack cycle
    data = wbs_dat_r;
    #1;
    wbs_cyc = 1'b0;
    wbs_stb = 1'b0;
  endtask

  task automatic check_word(input wb_data_t got, input wb_data_t exp, input string what);
    if (got !== exp) begin
      word_errors = word_errors + 1;
      $display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_byte(input i2c_byte_t got, input i2c_byte_t exp, input string what);
    if (got !== exp) begin
      byte_errors = byte_errors + 1;
      $display("MISMATCH at %0t: %s byte %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_event(input int starts, input int stops, input int exp_starts,
                             input int exp_stops, input string what);
    if (starts != exp_starts || stops != exp_stops) begin
      event_errors = event_errors + 1;
      $display("MISMATCH at %0t: %s saw %0d starts and %0d stops, expected %0d and %0d",
               $time, what, starts, stops, exp_starts, exp_stops);
    end
  endtask

  task automatic expect_bytes(input i2c_byte_t exp[$], input string what);
    if (rx_bytes.size() != exp.size()) begin
      byte_errors = byte_errors + 1;
      $display("Error: %s, the slave received %0d bytes but %0d were expected",
               what, rx_bytes.size(), exp.size());
    end
    for (int i = 0; i < exp.size() && i < rx_bytes.size(); i++) begin
      check_byte(rx_bytes[i], exp[i], what);
    end
  endtask

  task automatic clear_records;
    start_count = 0;
    stop_count  = 0;
    rx_bytes.delete();
  endtask

  // Poll until the engine is done and the queue has drained
  task automatic wait_idle;
    wb_data_t st;
    do begin
      wb_read(REG_STATUS, st);
    end while (st[ST_BUSY] || !st[ST_Q_EMPTY]);
  endtask

  task automatic reset_values;
    wb_data_t rd;
    wb_read(REG_STATUS, rd);
    check_word(rd, status_bits(0, 0, 1, 0, 0), "status after reset");
    wb_read(REG_PRESCALE, rd);
    check_word(rd, `I2C_DEFAULT_PRESCALE, "prescale after reset");
  endtask

  task automatic prescale_readback;
    wb_data_t rd;
    prescale_t val;
    rng_state = xorshift32(rng_state);
    val = rng_state[15:0];
    wb_write(REG_PRESCALE, val);
    wb_read(REG_PRESCALE, rd);
    check_word(rd, val, "prescale readback");
    wb_write(REG_PRESCALE, `I2C_DEFAULT_PRESCALE);
  endtask

  // Command goes in first, the engine drops data that comes while idle
  task automatic single_byte_write;
    i2c_addr_t addr;
    i2c_byte_t data;
    i2c_byte_t exp[$];
    wb_data_t  rd;
    rng_state = xorshift32(rng_state);
    addr = rng_state[6:0];
    data = rng_state[15:8];
    clear_records();
    wb_write(REG_COMMAND, command_word(1, 1, 0, 1, addr));
    wb_write(REG_DATA, data_word(data, 0));
    wait_idle();
    check_event(start_count, stop_count, 1, 1, "single write");
    exp.push_back({addr, 1'b0});
    exp.push_back(data);
    expect_bytes(exp, "single write");
    wb_read(REG_STATUS, rd);
    check_word(rd, status_bits(0, 0, 1, 0, 0), "status after single write");
  endtask

  task automatic block_write;
    i2c_addr_t addr;
    i2c_byte_t exp[$];
    rng_state = xorshift32(rng_state);
    addr = rng_state[6:0];
    clear_records();
    exp.push_back({addr, 1'b0});
    wb_write(REG_COMMAND, command_word(1, 0, 1, 1, addr));
    for (int i = 0; i < 3; i++) begin
      rng_state = xorshift32(rng_state);
      exp.push_back(rng_state[7:0]);
      wb_write(REG_DATA, data_word(rng_state[7:0], i == 2));
    end
    wait_idle();
    check_event(start_count, stop_count, 1, 1, "block write");
    expect_bytes(exp, "block write");
  endtask

  task automatic address_nack;
    i2c_addr_t addr;
    i2c_byte_t exp[$];
    wb_data_t  rd;
    rng_state = xorshift32(rng_state);
    addr = rng_state[6:0];
    clear_records();
    nack_addr = 1'b1;
    wb_write(REG_COMMAND, command_word(1, 1, 0, 1, addr));
    wb_write(REG_DATA, data_word(rng_state[15:8], 0));
    wait_idle();
    nack_addr = 1'b0;
    check_event(start_count, stop_count, 1, 1, "address NACK");
    exp.push_back({addr, 1'b0});
    expect_bytes(exp, "address NACK");
    wb_read(REG_STATUS, rd);
    check_word(rd, status_bits(0, 1, 1, 0, 0), "status after NACK");
    wb_write(REG_STATUS, status_bits(0, 1, 0, 0, 0));
    wb_read(REG_STATUS, rd);
    check_word(rd, status_bits(0, 0, 1, 0, 0), "status after miss_ack clear");
  endtask

  // Slow bus keeps the engine on the address byte while the queue fills
  task automatic queue_overflow;
    i2c_addr_t addr;
    i2c_byte_t exp[$];
    wb_data_t  rd;
    rng_state = xorshift32(rng_state);
    addr = rng_state[6:0];
    clear_records();
    exp.push_back({addr, 1'b0});
    wb_write(REG_PRESCALE, wb_data_t'(MAX_PRESCALE));
    wb_write(REG_COMMAND, command_word(1, 1, 0, 1, addr));
    for (int i = 0; i < `I2C_QUEUE_STAGES + 4; i++) begin
      rng_state = xorshift32(rng_state);
      if (i == 0) begin
        exp.push_back(rng_state[7:0]);
      end
      wb_write(REG_DATA, data_word(rng_state[7:0], 0));
    end
    wb_read(REG_STATUS, rd);
    check_word(rd, status_bits(1, 0, 0, 1, 1), "status after overflow");
    wb_write(REG_STATUS, status_bits(0, 0, 0, 0, 1));
    wb_read(REG_STATUS, rd);
    check_word(rd, status_bits(1, 0, 0, 1, 0), "status after overflow clear");
    // Only the first data word is sent, the rest is dropped when idle
    wait_idle();
    check_event(start_count, stop_count, 1, 1, "overflow write");
    expect_bytes(exp, "overflow write");
    wb_write(REG_PRESCALE, `I2C_DEFAULT_PRESCALE);
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    wbs_adr      = '0;
    wbs_dat_w    = '0;
    wbs_we       = 1'b0;
    wbs_stb      = 1'b0;
    wbs_cyc      = 1'b0;
    slave_sda    = 1'b1;
    nack_addr    = 1'b0;
    first_byte   = 1'b0;
    rx_shift     = '0;
    start_count  = 0;
    stop_count   = 0;
    word_errors  = 0;
    byte_errors  = 0;
    event_errors = 0;
    cycle_count  = 0;
    rng_state    = 32'h5a9a6d53;
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    reset_values();
    prescale_readback();
    single_byte_write();
    block_write();
    address_nack();
    queue_overflow();
    $display("Errors: word %0d, byte %0d, event %0d, assertion %0d",
             word_errors, byte_errors, event_errors, dut0.assert0.assert_errors);
    if (word_errors + byte_errors + event_errors + dut0.assert0.assert_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: tb_i2c_master_assert.sv
//********************
// Concurrent checks on the I2C write master
// Bound into the top level, reports through $error
//********************

`timescale 1ns/1ps

module tb_i2c_master_assert (
  input logic                   clk,
  input logic                   rst,
  input logic                   ack_i,
  input logic                   q_valid_i,
  input logic                   q_ready_i,
  input i2c_queue_pkg::q_word_t q_word_i,
  input logic                   scl_i,
  input logic                   sda_i
);

  // Failed assertion count
  int assert_errors = 0;

  // Single cycle Wishbone ack
  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack_i |=> !ack_i)
    else begin
      $error("Wishbone ack held high for two cycles");
      assert_errors++;
    end

  // Pushed word waits unchanged for stage 0
  push_held: assert property (@(posedge clk) disable iff (rst)
    q_valid_i && !q_ready_i |=> q_valid_i && $stable(q_word_i))
    else begin
      $error("Queue push word dropped or changed before ready");
      assert_errors++;
    end

  // Both bus lines released coming out of reset
  lines_released: assert property (@(posedge clk) rst |=> scl_i && sda_i)
    else begin
      $error("I2C lines not released after reset");
      assert_errors++;
    end

endmodule

bind i2c_master_wbs_top tb_i2c_master_assert assert0 (
  .clk(clk), .rst(rst), .ack_i(wbs_ack_o),
  .q_valid_i(chain_valid[0]), .q_ready_i(chain_ready[0]), .q_word_i(chain_word[0]),
  .scl_i(i2c_scl_o), .sda_i(i2c_sda_o)
);

// File: i2c_master_wbs_top.sv
//********************
// Wishbone slave I2C write master, top level
// Register block feeds a stage chain that feeds the engine
//********************

`timescale 1ns/1ps
`include "i2c_defines.svh"

module i2c_master_wbs_top (
  input  logic                  clk,
  input  logic                  rst,
  input  i2c_reg_pkg::wb_addr_t wbs_adr_i,
  input  i2c_reg_pkg::wb_data_t wbs_dat_i,
  output i2c_reg_pkg::wb_data_t wbs_dat_o,
  input  logic                  wbs_we_i,
  input  logic                  wbs_stb_i,
  input  logic                  wbs_cyc_i,
  output logic                  wbs_ack_o,
  input  logic                  i2c_sda_i,
  output logic                  i2c_scl_o,
  output logic                  i2c_sda_o
);
  import i2c_reg_pkg::*;
  import i2c_queue_pkg::*;

  localparam int N = `I2C_QUEUE_STAGES;

  // Index 0 is the register block, index N the engine input
  q_word_t    chain_word [N+1];
  logic [N:0] chain_valid;
  logic [N:0] chain_ready;
  prescale_t  prescale;
  logic       busy;
  logic       missed_ack;
  logic       q_empty;
  logic       q_full;

  assign q_empty = ~|chain_valid[N:1];
  assign q_full  = ~chain_ready[0];

  i2c_host_regs regs0 (
    .clk, .rst,
    .wbs_adr_i, .wbs_dat_i, .wbs_dat_o, .wbs_we_i, .wbs_stb_i, .wbs_cyc_i, .wbs_ack_o,
    .q_word_o(chain_word[0]), .q_valid_o(chain_valid[0]), .q_ready_i(chain_ready[0]),
    .busy_i(busy), .missed_ack_i(missed_ack), .q_empty_i(q_empty), .q_full_i(q_full),
    .prescale_o(prescale)
  );

  for (genvar k = 0; k < N; k++) begin : g_stage
    i2c_queue_stage stage (
      .clk, .rst,
      .in_word_i(chain_word[k]), .in_valid_i(chain_valid[k]), .in_ready_o(chain_ready[k]),
      .out_word_o(chain_word[k+1]), .out_valid_o(chain_valid[k+1]),
      .out_ready_i(chain_ready[k+1])
    );
  end

  i2c_write_engine engine0 (
    .clk, .rst,
    .q_word_i(chain_word[N]), .q_valid_i(chain_valid[N]), .q_ready_o(chain_ready[N]),
    .prescale_i(prescale), .sda_i(i2c_sda_i), .scl_o(i2c_scl_o), .sda_o(i2c_sda_o),
    .busy_o(busy), .missed_ack_o(missed_ack)
  );

endmodule

// File: i2c_write_engine.sv
//********************
// I2C write sequencer fed from the command/data queue
// Each bit is four quarters of prescale clk cycles
// Drives open-drain scl and sda, high means released
//********************

`timescale 1ns/1ps

module i2c_write_engine (
  input  logic                   clk,
  input  logic                   rst,
  input  i2c_queue_pkg::q_word_t q_word_i,
  input  logic                   q_valid_i,
  output logic                   q_ready_o,
  input  i2c_reg_pkg::prescale_t prescale_i,
  input  logic                   sda_i,
  output logic                   scl_o,
  output logic                   sda_o,
  output logic                   busy_o,
  output logic                   missed_ack_o
);
  import i2c_reg_pkg::*;
  import i2c_queue_pkg::*;

  localparam logic [2:0] S_IDLE      = 3'd0;
  localparam logic [2:0] S_WAIT_DATA = 3'd1;
  localparam logic [2:0] S_START     = 3'd2;
  localparam logic [2:0] S_BIT       = 3'd3;
  localparam logic [2:0] S_ACK       = 3'd4;
  localparam logic [2:0] S_STOP      = 3'd5;

  logic [2:0] state;
  logic [1:0] phase;
  logic [2:0] bit_cnt;
  prescale_t  cnt;
  prescale_t  quarter_len;
  i2c_byte_t  shreg;
  i2c_addr_t  cmd_addr;
  i2c_addr_t  last_addr;
  logic       cmd_wm;
  logic       cmd_stop;
  logic       byte_last;
  logic       is_addr;
  logic       nack;
  logic       bus_held;
  logic       timed;
  logic       tick;
  logic       bit_end;
  logic       need_start;
  logic       scl_d;
  logic       sda_d;

  assign quarter_len = (prescale_i > 16'd1) ? prescale_i - 16'd1 : '0;
  assign timed       = state inside {S_START, S_BIT, S_ACK, S_STOP};
  assign tick        = (cnt == '0);
  assign bit_end     = timed & tick & (phase == 2'd3);
  // Repeated start also when the target changes
  assign need_start  = q_word_i.payload.cmd.start | ~bus_held |
                       (q_word_i.payload.cmd.address != last_addr);
  // Idle also pops stray data words and drops them
  assign q_ready_o   = (state == S_IDLE) | ((state == S_WAIT_DATA) & q_word_i.is_data);
  assign busy_o      = (state != S_IDLE);

  // Line levels per quarter
  always_comb begin
    scl_d = ~bus_held;
    sda_d = ~bus_held;
    case (state)
      S_START: begin
        scl_d = (phase == 2'd1) || (phase == 2'd2);
        sda_d = (phase < 2'd2);
      end
      S_BIT: begin
        scl_d = (phase == 2'd1) || (phase == 2'd2);
        sda_d = shreg[7];
      end
      S_ACK: begin
        scl_d = (phase == 2'd1) || (phase == 2'd2);
        sda_d = 1'b1;
      end
      S_STOP: begin
        scl_d = (phase != 2'd0);
        sda_d = (phase >= 2'd2);
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= S_IDLE;
      phase        <= 2'd0;
      cnt          <= '0;
      bus_held     <= 1'b0;
      missed_ack_o <= 1'b0;
      scl_o        <= 1'b1;
      sda_o        <= 1'b1;
    end else begin
      missed_ack_o <= 1'b0;
      scl_o        <= scl_d;
      sda_o        <= sda_d;
      if (timed) begin
        if (tick) begin
          cnt   <= quarter_len;
          phase <= phase + 2'd1;
        end else begin
          cnt <= cnt - 16'd1;
        end
      end
      case (state)
        S_IDLE: begin
          if (q_valid_i && !q_word_i.is_data) begin
            cmd_addr <= q_word_i.payload.cmd.address;
            cmd_wm   <= q_word_i.payload.cmd.write_multiple;
            cmd_stop <= q_word_i.payload.cmd.stop;
            cnt      <= quarter_len;
            if (q_word_i.payload.cmd.write || q_word_i.payload.cmd.write_multiple) begin
              if (need_start) begin
                state <= S_START;
                // Idle bus already has scl high, skip the first quarter
                phase <= bus_held ? 2'd0 : 2'd1;
              end else begin
                state <= S_WAIT_DATA;
              end
            end else if (q_word_i.payload.cmd.stop && bus_held) begin
              state <= S_STOP;
              phase <= 2'd0;
            end
          end
        end
        S_WAIT_DATA: begin
          if (q_valid_i) begin
            phase <= 2'd0;
            cnt   <= quarter_len;
            if (q_word_i.is_data) begin
              shreg     <= q_word_i.payload.data.data_byte;
              byte_last <= q_word_i.payload.data.last;
              is_addr   <= 1'b0;
              bit_cnt   <= 3'd0;
              state     <= S_BIT;
            end else begin
              // Next command ends this one, it stays queued
              state <= cmd_stop ? S_STOP : S_IDLE;
            end
          end
        end
        S_START: begin
          if (bit_end) begin
            bus_held  <= 1'b1;
            last_addr <= cmd_addr;
            shreg     <= {cmd_addr, 1'b0};
            is_addr   <= 1'b1;
            bit_cnt   <= 3'd0;
            state     <= S_BIT;
          end
        end
        S_BIT: begin
          if (bit_end) begin
            shreg   <= {shreg[6:0], 1'b0};
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              state <= S_ACK;
            end
          end
        end
        S_ACK: begin
          // Sample late in the scl high time
          if (tick && phase == 2'd2) begin
            nack <= sda_i;
          end
          if (bit_end) begin
            if (nack) begin
              missed_ack_o <= 1'b1;
              state        <= S_STOP;
            end else if (is_addr || (cmd_wm && !byte_last)) begin
              state <= S_WAIT_DATA;
            end else begin
              state <= cmd_stop ? S_STOP : S_IDLE;
            end
          end
        end
        S_STOP: begin
          if (bit_end) begin
            bus_held <= 1'b0;
            state    <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: i2c_queue_stage.sv
//********************
// One-entry elastic stage of the command/data queue
// Chain copies back to back for more depth
//********************

`timescale 1ns/1ps

module i2c_queue_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  i2c_queue_pkg::q_word_t in_word_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output i2c_queue_pkg::q_word_t out_word_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i
);

  // Empty, or the held word leaves this cycle
  assign in_ready_o = ~out_valid_o | out_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      out_word_o <= in_word_i;
    end
  end

endmodule

// File: i2c_host_regs.sv
//********************
// Wishbone register block of the I2C write master
// Pushes command and data words into the queue in write order
// Holds prescale and the sticky status bits
//********************

`timescale 1ns/1ps
`include "i2c_defines.svh"

module i2c_host_regs (
  input  logic                   clk,
  input  logic                   rst,
  input  i2c_reg_pkg::wb_addr_t  wbs_adr_i,
  input  i2c_reg_pkg::wb_data_t  wbs_dat_i,
  output i2c_reg_pkg::wb_data_t  wbs_dat_o,
  input  logic                   wbs_we_i,
  input  logic                   wbs_stb_i,
  input  logic                   wbs_cyc_i,
  output logic                   wbs_ack_o,
  output i2c_queue_pkg::q_word_t q_word_o,
  output logic                   q_valid_o,
  input  logic                   q_ready_i,
  input  logic                   busy_i,
  input  logic                   missed_ack_i,
  input  logic                   q_empty_i,
  input  logic                   q_full_i,
  output i2c_reg_pkg::prescale_t prescale_o
);
  import i2c_reg_pkg::*;
  import i2c_queue_pkg::*;

  logic     access;
  logic     wr_access;
  logic     push_req;
  logic     push_ok;
  q_word_t  push_word;
  q_cmd_t   last_cmd;
  wb_data_t rd_data;
  logic     miss_ack;
  logic     q_ovf;

  // New access only while ack is low, so each access acts once
  assign access    = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;
  assign wr_access = access & wbs_we_i;
  // Slot must be free and stage 0 able to take it next cycle
  assign push_ok   = push_req & q_ready_i & ~q_valid_o;

  // Queue word built straight from the bus data
  always_comb begin
    push_word = '0;
    push_req  = 1'b0;
    if (wr_access && wbs_adr_i == REG_COMMAND) begin
      push_word.is_data                    = 1'b0;
      push_word.payload.cmd.address        = wbs_dat_i[6:0];
      push_word.payload.cmd.start          = wbs_dat_i[8];
      push_word.payload.cmd.write          = wbs_dat_i[10];
      push_word.payload.cmd.write_multiple = wbs_dat_i[11];
      push_word.payload.cmd.stop           = wbs_dat_i[12];
      // Bit 9 is reserved and never counts as a command
      push_req = wbs_dat_i[8] | wbs_dat_i[10] | wbs_dat_i[11] | wbs_dat_i[12];
    end else if (wr_access && wbs_adr_i == REG_DATA) begin
      push_word.is_data                = 1'b1;
      push_word.payload.data.data_byte = wbs_dat_i[7:0];
      push_word.payload.data.last      = wbs_dat_i[9];
      push_req = 1'b1;
    end
  end

  // Read mux
  always_comb begin
    rd_data = '0;
    case (wbs_adr_i)
      REG_STATUS: begin
        rd_data[ST_BUSY]     = busy_i;
        rd_data[ST_MISS_ACK] = miss_ack;
        rd_data[ST_Q_EMPTY]  = q_empty_i;
        rd_data[ST_Q_FULL]   = q_full_i;
        rd_data[ST_Q_OVF]    = q_ovf;
      end
      REG_COMMAND: rd_data = {3'b000, last_cmd.stop, last_cmd.write_multiple,
                              last_cmd.write, 1'b0, last_cmd.start, 1'b0, last_cmd.address};
      REG_PRESCALE: rd_data = prescale_o;
      default: rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wbs_ack_o  <= 1'b0;
      q_valid_o  <= 1'b0;
      miss_ack   <= 1'b0;
      q_ovf      <= 1'b0;
      prescale_o <= `I2C_DEFAULT_PRESCALE;
    end else begin
      wbs_ack_o <= access;
      if (q_ready_i) begin
        q_valid_o <= 1'b0;
      end
      if (push_ok) begin
        q_valid_o <= 1'b1;
      end
      // Set wins over a clear in the same cycle
      if (missed_ack_i) begin
        miss_ack <= 1'b1;
      end else if (wr_access && wbs_adr_i == REG_STATUS && wbs_dat_i[ST_MISS_ACK]) begin
        miss_ack <= 1'b0;
      end
      if (push_req && !push_ok) begin
        q_ovf <= 1'b1;
      end else if (wr_access && wbs_adr_i == REG_STATUS && wbs_dat_i[ST_Q_OVF]) begin
        q_ovf <= 1'b0;
      end
      if (wr_access && wbs_adr_i == REG_PRESCALE) begin
        prescale_o <= wbs_dat_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    wbs_dat_o <= (access && !wbs_we_i) ? rd_data : '0;
    if (push_ok) begin
      q_word_o <= push_word;
    end
    // Kept even when no flag is set, for readback
    if (wr_access && wbs_adr_i == REG_COMMAND) begin
      last_cmd <= push_word.payload.cmd;
    end
  end

endmodule

// File: i2c_queue_pkg.sv
//********************
// Word format of the shared command/data queue
// Tag bit picks the view of the 12-bit payload
//********************

package i2c_queue_pkg;

  typedef logic [6:0] i2c_addr_t;
  typedef logic [7:0] i2c_byte_t;

  // Command view, same bit meaning as the COMMAND register flags
  typedef struct packed {
    i2c_addr_t address;
    logic      start;
    logic      write;
    logic      write_multiple;
    logic      stop;
    logic      pad;
  } q_cmd_t;

  // Data view, last marks the end of a block write
  typedef struct packed {
    i2c_byte_t  data_byte;
    logic       last;
    logic [2:0] pad;
  } q_data_t;

  typedef union packed {
    q_cmd_t  cmd;
    q_data_t data;
  } q_payload_u;

  typedef struct packed {
    logic       is_data;
    q_payload_u payload;
  } q_word_t;

endpackage

// File: i2c_reg_pkg.sv
//********************
// Host side register map of the I2C write master
// Wishbone word types, register addresses, status bit positions
//********************

package i2c_reg_pkg;

  // Wishbone address and data
  typedef logic [2:0]  wb_addr_t;
  typedef logic [15:0] wb_data_t;

  // Byte addresses of the 16-bit registers
  localparam wb_addr_t REG_STATUS   = 3'd0;
  localparam wb_addr_t REG_COMMAND  = 3'd2;
  localparam wb_addr_t REG_DATA     = 3'd4;
  localparam wb_addr_t REG_PRESCALE = 3'd6;

  // Status bits, all others read as zero
  localparam int unsigned ST_BUSY     = 0;
  localparam int unsigned ST_MISS_ACK = 3;
  localparam int unsigned ST_Q_EMPTY  = 8;
  localparam int unsigned ST_Q_FULL   = 9;
  localparam int unsigned ST_Q_OVF    = 10;

  typedef logic [15:0] prescale_t;

endpackage

// File: i2c_defines.svh
//********************
// Build-time constants of the I2C write master
// Include in any file that needs queue depth or reset prescale
//********************

`ifndef I2C_DEFINES_SVH
`define I2C_DEFINES_SVH

// Number of register stages in the command/data queue, 1 or more
`define I2C_QUEUE_STAGES 4

// Prescale after reset, quarter bit time in clk cycles
`define I2C_DEFAULT_PRESCALE 16'd4

`endif
